// File: verilog/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// data word width in bits
`define MEM_XLEN 64

// byte address width
`define MEM_ADDR_W 32

// bank depth in 64-bit words
// address bits above the bank size are ignored
`define MEM_DEPTH_WORDS 1024

// first fetch address out of reset
`define MEM_RESET_PC 32'h0000_0000

`endif

// File: verilog/mem_pkg.sv
`include "mem_settings.svh"

package mem_pkg;

  // data word, byte address, lane mask, instruction
  typedef logic [`MEM_XLEN-1:0] xlen_t;
  typedef logic [`MEM_ADDR_W-1:0] addr_t;
  typedef logic [`MEM_XLEN/8-1:0] mask_t;
  typedef logic [31:0] instr_t;

  // load/store access size
  typedef enum logic [1:0] {SZ_B, SZ_H, SZ_W, SZ_D} acc_size_t;

  // arbiter read machine
  typedef enum logic [1:0] {RD_PREIDLE, RD_IDLE, RD_ACCESS, RD_RESP} rd_state_t;

  // arbiter write machine
  typedef enum logic [1:0] {WR_PREIDLE, WR_IDLE, WR_COMMIT} wr_state_t;

  // fetch unit
  typedef enum logic {F_IDLE, F_WAIT} fetch_state_t;

  // load/store unit
  typedef enum logic [1:0] {L_IDLE, L_READ, L_WRITE} lsu_state_t;

endpackage

// File: verilog/sram_bank.sv
`timescale 1ns/100ps
`include "mem_settings.svh"

module sram_bank (
  input  logic           clk,
  input  logic           rd_en_i,
  input  mem_pkg::addr_t rd_addr_i,
  output mem_pkg::xlen_t rd_data_o,
  input  logic           wr_en_i,
  input  mem_pkg::addr_t wr_addr_i,
  input  mem_pkg::mask_t wr_mask_i,
  input  mem_pkg::xlen_t wr_data_i
);
  import mem_pkg::*;

  localparam int LANES = $bits(mask_t);
  localparam int OFF_W = $clog2(LANES);
  localparam int IDX_W = $clog2(`MEM_DEPTH_WORDS);

  xlen_t            mem_q [`MEM_DEPTH_WORDS];
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;

  // word index, byte offset dropped
  assign rd_idx = rd_addr_i[OFF_W +: IDX_W];
  assign wr_idx = wr_addr_i[OFF_W +: IDX_W];

  // registered read, old data on a same-word write
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_idx];
    end
  end

  // byte-lane write
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      for (int k = 0; k < LANES; k++) begin
        if (wr_mask_i[k]) begin
          mem_q[wr_idx][8*k +: 8] <= wr_data_i[8*k +: 8];
        end
      end
    end
  end

endmodule

// File: verilog/ram_arb.sv
`timescale 1ns/100ps

module ram_arb (
  input  logic           clk,
  input  logic           rst,
  // fetch read port
  input  logic           if_valid_i,
  input  mem_pkg::addr_t if_addr_i,
  input  mem_pkg::mask_t if_rmask_i,
  output mem_pkg::xlen_t if_rdata_o,
  output logic           if_rdata_valid_o,
  // load/store read port
  input  logic           mem_valid_i,
  input  mem_pkg::addr_t mem_addr_i,
  input  mem_pkg::mask_t mem_rmask_i,
  output mem_pkg::xlen_t mem_rdata_o,
  output logic           mem_rdata_valid_o,
  // load/store write port, not shared
  input  logic           mem_write_valid_i,
  input  mem_pkg::addr_t mem_write_addr_i,
  input  mem_pkg::mask_t mem_wmask_i,
  input  mem_pkg::xlen_t mem_wdata_i,
  output logic           mem_wdata_ready_o,
  // bank side
  output logic           bank_rd_en_o,
  output mem_pkg::addr_t bank_rd_addr_o,
  input  mem_pkg::xlen_t bank_rd_data_i,
  output logic           bank_wr_en_o,
  output mem_pkg::addr_t bank_wr_addr_o,
  output mem_pkg::mask_t bank_wr_mask_o,
  output mem_pkg::xlen_t bank_wr_data_o
);
  import mem_pkg::*;

  localparam int LANES = $bits(mask_t);

  rd_state_t rd_state;
  logic      grant_mem;
  logic      grant_valid;
  addr_t     rd_addr_q;
  mask_t     rd_mask_q;
  xlen_t     rd_lanes;
  xlen_t     resp_data;
  logic      resp_active;

  wr_state_t wr_state;
  logic      wr_en_q;
  addr_t     wr_addr_q;
  mask_t     wr_mask_q;
  xlen_t     wr_data_q;

  // granted requester still holding its valid
  assign grant_valid = grant_mem ? mem_valid_i : if_valid_i;

  // read machine, data side wins over fetch
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state  <= RD_PREIDLE;
      grant_mem <= 1'b0;
    end else begin
      case (rd_state)
        RD_PREIDLE: begin
          rd_state <= RD_IDLE;
        end
        RD_IDLE: begin
          if (mem_valid_i) begin
            grant_mem <= 1'b1;
            rd_state  <= RD_ACCESS;
          end else if (if_valid_i) begin
            grant_mem <= 1'b0;
            rd_state  <= RD_ACCESS;
          end
        end
        RD_ACCESS: begin
          // a dropped valid cancels the access
          rd_state <= grant_valid ? RD_RESP : RD_IDLE;
        end
        default: begin
          rd_state <= RD_IDLE;
        end
      endcase
    end
  end

  // address and mask captured with the grant
  always_ff @(posedge clk) begin
    if (rd_state == RD_IDLE) begin
      rd_addr_q <= mem_valid_i ? mem_addr_i : if_addr_i;
      rd_mask_q <= mem_valid_i ? mem_rmask_i : if_rmask_i;
    end
  end

  assign bank_rd_en_o   = (rd_state == RD_ACCESS);
  assign bank_rd_addr_o = rd_addr_q;

  // lanes outside the request mask return zero
  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      rd_lanes[8*k +: 8] = {8{rd_mask_q[k]}};
    end
  end

  assign resp_data   = bank_rd_data_i & rd_lanes;
  assign resp_active = (rd_state == RD_RESP);

  // response goes to the granted peer only
  assign if_rdata_valid_o  = resp_active & ~grant_mem;
  assign mem_rdata_valid_o = resp_active & grant_mem;
  assign if_rdata_o        = if_rdata_valid_o ? resp_data : '0;
  assign mem_rdata_o       = mem_rdata_valid_o ? resp_data : '0;

  // write machine
  // commit stays one extra cycle for the ready pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= WR_PREIDLE;
      wr_en_q  <= 1'b0;
    end else begin
      case (wr_state)
        WR_PREIDLE: begin
          wr_state <= WR_IDLE;
        end
        WR_IDLE: begin
          if (mem_write_valid_i) begin
            wr_state <= WR_COMMIT;
          end
        end
        WR_COMMIT: begin
          if (wr_en_q) begin
            wr_en_q  <= 1'b0;
            wr_state <= WR_IDLE;
          end else if (mem_write_valid_i) begin
            wr_en_q <= 1'b1;
          end else begin
            // requester gave up, write dropped
            wr_state <= WR_IDLE;
          end
        end
        default: begin
          wr_state <= WR_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_state == WR_IDLE && mem_write_valid_i) begin
      wr_addr_q <= mem_write_addr_i;
      wr_mask_q <= mem_wmask_i;
      wr_data_q <= mem_wdata_i;
    end
  end

  assign bank_wr_en_o      = wr_en_q;
  assign bank_wr_addr_o    = wr_addr_q;
  assign bank_wr_mask_o    = wr_mask_q;
  assign bank_wr_data_o    = wr_data_q;
  assign mem_wdata_ready_o = wr_en_q;

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/100ps
`include "mem_settings.svh"

module fetch_unit (
  input  logic            clk,
  input  logic            rst,
  input  logic            fetch_en_i,
  input  logic            redirect_i,
  input  mem_pkg::addr_t  redirect_pc_i,
  output logic            if_valid_o,
  output mem_pkg::addr_t  if_addr_o,
  output mem_pkg::mask_t  if_rmask_o,
  input  mem_pkg::xlen_t  if_rdata_i,
  input  logic            if_rdata_valid_i,
  output logic            instr_valid_o,
  output mem_pkg::instr_t instr_o,
  output mem_pkg::addr_t  instr_pc_o
);
  import mem_pkg::*;

  fetch_state_t state;
  addr_t        pc;
  logic         take;

  // doubleword holding pc, lanes of the selected half
  assign if_addr_o  = {pc[$bits(addr_t)-1:3], 3'b000};
  assign if_rmask_o = pc[2] ? 8'hF0 : 8'h0F;

  // response accepted unless a redirect kills it
  assign take = (state == F_WAIT) && if_rdata_valid_i && !redirect_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= F_IDLE;
      pc            <= `MEM_RESET_PC;
      if_valid_o    <= 1'b0;
      instr_valid_o <= 1'b0;
    end else begin
      instr_valid_o <= take;
      if (redirect_i) begin
        // valid low for a cycle cancels the old access
        pc         <= redirect_pc_i;
        if_valid_o <= 1'b0;
        state      <= F_IDLE;
      end else begin
        case (state)
          F_IDLE: begin
            if (fetch_en_i) begin
              if_valid_o <= 1'b1;
              state      <= F_WAIT;
            end
          end
          F_WAIT: begin
            if (if_rdata_valid_i) begin
              pc <= pc + 4;
            end
            if (!fetch_en_i) begin
              if_valid_o <= 1'b0;
              state      <= F_IDLE;
            end
          end
          default: begin
            state <= F_IDLE;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      instr_o    <= pc[2] ? if_rdata_i[63:32] : if_rdata_i[31:0];
      instr_pc_o <= pc;
    end
  end

endmodule

// File: verilog/load_store_unit.sv
`timescale 1ns/100ps

module load_store_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               lsu_req_i,
  input  logic               lsu_we_i,
  input  mem_pkg::addr_t     lsu_addr_i,
  input  mem_pkg::acc_size_t lsu_size_i,
  input  logic               lsu_unsigned_i,
  input  mem_pkg::xlen_t     lsu_wdata_i,
  output logic               lsu_done_o,
  output logic               lsu_err_o,
  output mem_pkg::xlen_t     lsu_rdata_o,
  // memory ports
  output logic               mem_valid_o,
  output mem_pkg::addr_t     mem_addr_o,
  output mem_pkg::mask_t     mem_rmask_o,
  input  mem_pkg::xlen_t     mem_rdata_i,
  input  logic               mem_rdata_valid_i,
  output logic               mem_write_valid_o,
  output mem_pkg::addr_t     mem_write_addr_o,
  output mem_pkg::mask_t     mem_wmask_o,
  output mem_pkg::xlen_t     mem_wdata_o,
  input  logic               mem_wdata_ready_i
);
  import mem_pkg::*;

  lsu_state_t state;
  logic [2:0] offset;
  logic       misaligned;
  mask_t      lane_mask;
  addr_t      word_addr;
  acc_size_t  size_q;
  logic       unsigned_q;
  logic [2:0] offset_q;
  xlen_t      shifted;
  xlen_t      load_val;

  assign offset    = lsu_addr_i[2:0];
  assign word_addr = {lsu_addr_i[$bits(addr_t)-1:3], 3'b000};

  // alignment check and lane mask per size
  always_comb begin
    case (lsu_size_i)
      SZ_B: begin
        misaligned = 1'b0;
        lane_mask  = 8'h01 << offset;
      end
      SZ_H: begin
        misaligned = offset[0];
        lane_mask  = 8'h03 << offset;
      end
      SZ_W: begin
        misaligned = |offset[1:0];
        lane_mask  = 8'h0F << offset;
      end
      default: begin
        misaligned = |offset;
        lane_mask  = 8'hFF;
      end
    endcase
  end

  // bring the loaded lanes down to bit 0, then extend
  assign shifted = mem_rdata_i >> {offset_q, 3'b000};

  always_comb begin
    case (size_q)
      SZ_B: load_val = unsigned_q ? {56'b0, shifted[7:0]} : {{56{shifted[7]}}, shifted[7:0]};
      SZ_H: load_val = unsigned_q ? {48'b0, shifted[15:0]} : {{48{shifted[15]}}, shifted[15:0]};
      SZ_W: load_val = unsigned_q ? {32'b0, shifted[31:0]} : {{32{shifted[31]}}, shifted[31:0]};
      default: load_val = shifted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state             <= L_IDLE;
      mem_valid_o       <= 1'b0;
      mem_write_valid_o <= 1'b0;
      lsu_done_o        <= 1'b0;
      lsu_err_o         <= 1'b0;
    end else begin
      lsu_done_o <= 1'b0;
      lsu_err_o  <= 1'b0;
      case (state)
        L_IDLE: begin
          if (lsu_req_i) begin
            if (misaligned) begin
              // rejected without touching memory
              lsu_done_o <= 1'b1;
              lsu_err_o  <= 1'b1;
            end else if (lsu_we_i) begin
              mem_write_valid_o <= 1'b1;
              state             <= L_WRITE;
            end else begin
              mem_valid_o <= 1'b1;
              state       <= L_READ;
            end
          end
        end
        L_READ: begin
          if (mem_rdata_valid_i) begin
            mem_valid_o <= 1'b0;
            lsu_done_o  <= 1'b1;
            state       <= L_IDLE;
          end
        end
        L_WRITE: begin
          if (mem_wdata_ready_i) begin
            mem_write_valid_o <= 1'b0;
            lsu_done_o        <= 1'b1;
            state             <= L_IDLE;
          end
        end
        default: begin
          state <= L_IDLE;
        end
      endcase
    end
  end

  // request payload held for the whole access
  always_ff @(posedge clk) begin
    if (state == L_IDLE && lsu_req_i) begin
      mem_addr_o       <= word_addr;
      mem_rmask_o      <= lane_mask;
      mem_write_addr_o <= word_addr;
      mem_wmask_o      <= lane_mask;
      mem_wdata_o      <= lsu_wdata_i << {offset, 3'b000};
      size_q           <= lsu_size_i;
      unsigned_q       <= lsu_unsigned_i;
      offset_q         <= offset;
    end
  end

  always_ff @(posedge clk) begin
    if (state == L_READ && mem_rdata_valid_i) begin
      lsu_rdata_o <= load_val;
    end
  end

endmodule

// File: verilog/mem_subsys.sv
`timescale 1ns/100ps

module mem_subsys (
  input  logic               clk,
  input  logic               rst,
  // fetch control and instruction stream
  input  logic               fetch_en_i,
  input  logic               redirect_i,
  input  mem_pkg::addr_t     redirect_pc_i,
  output logic               instr_valid_o,
  output mem_pkg::instr_t    instr_o,
  output mem_pkg::addr_t     instr_pc_o,
  // load/store requests
  input  logic               lsu_req_i,
  input  logic               lsu_we_i,
  input  mem_pkg::addr_t     lsu_addr_i,
  input  mem_pkg::acc_size_t lsu_size_i,
  input  logic               lsu_unsigned_i,
  input  mem_pkg::xlen_t     lsu_wdata_i,
  output logic               lsu_done_o,
  output logic               lsu_err_o,
  output mem_pkg::xlen_t     lsu_rdata_o
);
  import mem_pkg::*;

  // fetch to arbiter
  logic  if_valid;
  addr_t if_addr;
  mask_t if_rmask;
  xlen_t if_rdata;
  logic  if_rdata_valid;

  // load/store to arbiter
  logic  mem_valid;
  addr_t mem_addr;
  mask_t mem_rmask;
  xlen_t mem_rdata;
  logic  mem_rdata_valid;
  logic  mem_write_valid;
  addr_t mem_write_addr;
  mask_t mem_wmask;
  xlen_t mem_wdata;
  logic  mem_wdata_ready;

  // arbiter to bank
  logic  bank_rd_en;
  addr_t bank_rd_addr;
  xlen_t bank_rd_data;
  logic  bank_wr_en;
  addr_t bank_wr_addr;
  mask_t bank_wr_mask;
  xlen_t bank_wr_data;

  fetch_unit fetch_unit_inst (
    .clk              (clk),
    .rst              (rst),
    .fetch_en_i       (fetch_en_i),
    .redirect_i       (redirect_i),
    .redirect_pc_i    (redirect_pc_i),
    .if_valid_o       (if_valid),
    .if_addr_o        (if_addr),
    .if_rmask_o       (if_rmask),
    .if_rdata_i       (if_rdata),
    .if_rdata_valid_i (if_rdata_valid),
    .instr_valid_o    (instr_valid_o),
    .instr_o          (instr_o),
    .instr_pc_o       (instr_pc_o)
  );

  load_store_unit load_store_unit_inst (
    .clk               (clk),
    .rst               (rst),
    .lsu_req_i         (lsu_req_i),
    .lsu_we_i          (lsu_we_i),
    .lsu_addr_i        (lsu_addr_i),
    .lsu_size_i        (lsu_size_i),
    .lsu_unsigned_i    (lsu_unsigned_i),
    .lsu_wdata_i       (lsu_wdata_i),
    .lsu_done_o        (lsu_done_o),
    .lsu_err_o         (lsu_err_o),
    .lsu_rdata_o       (lsu_rdata_o),
    .mem_valid_o       (mem_valid),
    .mem_addr_o        (mem_addr),
    .mem_rmask_o       (mem_rmask),
    .mem_rdata_i       (mem_rdata),
    .mem_rdata_valid_i (mem_rdata_valid),
    .mem_write_valid_o (mem_write_valid),
    .mem_write_addr_o  (mem_write_addr),
    .mem_wmask_o       (mem_wmask),
    .mem_wdata_o       (mem_wdata),
    .mem_wdata_ready_i (mem_wdata_ready)
  );

  ram_arb ram_arb_inst (
    .clk               (clk),
    .rst               (rst),
    .if_valid_i        (if_valid),
    .if_addr_i         (if_addr),
    .if_rmask_i        (if_rmask),
    .if_rdata_o        (if_rdata),
    .if_rdata_valid_o  (if_rdata_valid),
    .mem_valid_i       (mem_valid),
    .mem_addr_i        (mem_addr),
    .mem_rmask_i       (mem_rmask),
    .mem_rdata_o       (mem_rdata),
    .mem_rdata_valid_o (mem_rdata_valid),
    .mem_write_valid_i (mem_write_valid),
    .mem_write_addr_i  (mem_write_addr),
    .mem_wmask_i       (mem_wmask),
    .mem_wdata_i       (mem_wdata),
    .mem_wdata_ready_o (mem_wdata_ready),
    .bank_rd_en_o      (bank_rd_en),
    .bank_rd_addr_o    (bank_rd_addr),
    .bank_rd_data_i    (bank_rd_data),
    .bank_wr_en_o      (bank_wr_en),
    .bank_wr_addr_o    (bank_wr_addr),
    .bank_wr_mask_o    (bank_wr_mask),
    .bank_wr_data_o    (bank_wr_data)
  );

  sram_bank sram_bank_inst (
    .clk       (clk),
    .rd_en_i   (bank_rd_en),
    .rd_addr_i (bank_rd_addr),
    .rd_data_o (bank_rd_data),
    .wr_en_i   (bank_wr_en),
    .wr_addr_i (bank_wr_addr),
    .wr_mask_i (bank_wr_mask),
    .wr_data_i (bank_wr_data)
  );

endmodule

// File: tb/mem_subsys_assertions.sv
`timescale 1ns/100ps

module mem_subsys_assertions (
  input logic clk,
  input logic rst,
  input logic if_rdata_valid_i,
  input logic mem_rdata_valid_i,
  input logic mem_wdata_ready_i,
  input logic bank_rd_en_i,
  input logic bank_wr_en_i
);
  // read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // the read port answers one peer at a time
  single_response: assert property (@(posedge clk) disable iff (rst)
    !(if_rdata_valid_i && mem_rdata_valid_i))
    else begin
      $error("fetch and data read responses high together");
      fail_count++;
    end

  if_pulse_width: assert property (@(posedge clk) disable iff (rst)
    if_rdata_valid_i |=> !if_rdata_valid_i)
    else begin
      $error("fetch read response longer than one cycle");
      fail_count++;
    end

  mem_pulse_width: assert property (@(posedge clk) disable iff (rst)
    mem_rdata_valid_i |=> !mem_rdata_valid_i)
    else begin
      $error("data read response longer than one cycle");
      fail_count++;
    end

  ready_pulse_width: assert property (@(posedge clk) disable iff (rst)
    mem_wdata_ready_i |=> !mem_wdata_ready_i)
    else begin
      $error("write ready longer than one cycle");
      fail_count++;
    end

  no_write_after_reset: assert property (@(posedge clk)
    rst |=> !bank_wr_en_i)
    else begin
      $error("bank write enable high right after reset");
      fail_count++;
    end

  // a response needs a bank read in the cycle before
  no_response_without_read: assert property (@(posedge clk) disable iff (rst)
    (if_rdata_valid_i || mem_rdata_valid_i) |-> $past(bank_rd_en_i))
    else begin
      $error("read response without a granted bank read");
      fail_count++;
    end

endmodule

bind ram_arb mem_subsys_assertions mem_subsys_assertions_inst (
  .clk               (clk),
  .rst               (rst),
  .if_rdata_valid_i  (if_rdata_valid_o),
  .mem_rdata_valid_i (mem_rdata_valid_o),
  .mem_wdata_ready_i (mem_wdata_ready_o),
  .bank_rd_en_i      (bank_rd_en_o),
  .bank_wr_en_i      (bank_wr_en_o)
);

// File: tb/mem_subsys_tb.sv
`timescale 1ns/100ps
`include "mem_settings.svh"

module mem_subsys_tb;
  import mem_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int OP_CYCLES    = 20;
  localparam int FILL_WORDS   = 512;
  localparam int N_STORES     = 48;
  localparam int N_MISALIGNED = 16;
  localparam int N_FETCH      = 40;
  localparam int N_MIXED      = 64;
  localparam int N_REDIRECTS  = 8;
  localparam int TOTAL_OPS    = RESET_CYCLES + 20 + FILL_WORDS + 2 * N_STORES
                                + 3 * N_MISALIGNED + N_FETCH + N_MIXED + 4 * N_REDIRECTS;
  localparam int MODEL_BYTES  = `MEM_DEPTH_WORDS * 8;
  localparam addr_t DATA_BASE = 32'h0000_1000;
  // address bits above the bank
  localparam addr_t HIGH_BITS = ~addr_t'(MODEL_BYTES - 1);

  logic      clk;
  logic      rst;
  logic      fetch_en;
  logic      redirect;
  addr_t     redirect_pc;
  logic      instr_valid;
  instr_t    instr;
  addr_t     instr_pc;
  logic      lsu_req;
  logic      lsu_we;
  addr_t     lsu_addr;
  acc_size_t lsu_size;
  logic      lsu_unsigned;
  xlen_t     lsu_wdata;
  logic      lsu_done;
  logic      lsu_err;
  xlen_t     lsu_rdata;

  integer      seed;
  int          check_count;
  int          error_count;
  int          test_start_errors;
  int          instr_count;
  int unsigned assert_fails;
  addr_t       expect_pc;
  logic        after_redirect;
  logic [7:0]  model_mem [MODEL_BYTES];
  addr_t       addr_list [$];
  acc_size_t   size_list [$];

  mem_subsys mem_subsys_inst (
    .clk            (clk),
    .rst            (rst),
    .fetch_en_i     (fetch_en),
    .redirect_i     (redirect),
    .redirect_pc_i  (redirect_pc),
    .instr_valid_o  (instr_valid),
    .instr_o        (instr),
    .instr_pc_o     (instr_pc),
    .lsu_req_i      (lsu_req),
    .lsu_we_i       (lsu_we),
    .lsu_addr_i     (lsu_addr),
    .lsu_size_i     (lsu_size),
    .lsu_unsigned_i (lsu_unsigned),
    .lsu_wdata_i    (lsu_wdata),
    .lsu_done_o     (lsu_done),
    .lsu_err_o      (lsu_err),
    .lsu_rdata_o    (lsu_rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("FAIL %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic int size_bytes(acc_size_t sz);
    return 1 << int'(sz);
  endfunction

  function automatic int byte_index(addr_t a);
    return int'(a & addr_t'(MODEL_BYTES - 1));
  endfunction

  // reference memory, little endian bytes
  function automatic void model_store(addr_t addr, acc_size_t sz, xlen_t data);
    for (int i = 0; i < size_bytes(sz); i++) begin
      model_mem[byte_index(addr + i)] = data[8*i +: 8];
    end
  endfunction

  function automatic xlen_t model_load(addr_t addr, acc_size_t sz, logic uns);
    xlen_t val;
    int    n;
    n   = size_bytes(sz);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val[8*i +: 8] = model_mem[byte_index(addr + i)];
    end
    if (!uns && n < 8 && val[8*n-1]) begin
      for (int i = 8 * n; i < 64; i++) begin
        val[i] = 1'b1;
      end
    end
    return val;
  endfunction

  function automatic instr_t model_instr(addr_t pc);
    instr_t val;
    for (int i = 0; i < 4; i++) begin
      val[8*i +: 8] = model_mem[byte_index(pc + i)];
    end
    return val;
  endfunction

  function automatic addr_t aligned_data_addr(acc_size_t sz);
    return (DATA_BASE + rand_below(4096)) & ~addr_t'(size_bytes(sz) - 1);
  endfunction

  // request held for one edge, edges counts from sampling to done
  task automatic lsu_access(input logic we, input addr_t addr, input acc_size_t sz,
                            input logic uns, input xlen_t wdata,
                            output xlen_t rdata, output logic err, output int edges);
    int seen;
    lsu_req      = 1'b1;
    lsu_we       = we;
    lsu_addr     = addr;
    lsu_size     = sz;
    lsu_unsigned = uns;
    lsu_wdata    = wdata;
    edges        = -1;
    seen         = 0;
    while (!seen && edges < OP_CYCLES) begin
      @(negedge clk);
      lsu_req = 1'b0;
      edges++;
      seen = lsu_done;
    end
    rdata = lsu_rdata;
    err   = lsu_err;
    if (!seen) begin
      $display("load/store access at %h never completed", addr);
      error_count++;
    end
  endtask

  task automatic store_op(input addr_t addr, input acc_size_t sz, input xlen_t data,
                          input logic exact);
    xlen_t rdata;
    logic  err;
    int    edges;
    lsu_access(1'b1, addr, sz, 1'b0, data, rdata, err, edges);
    check_value("store error flag", err, 0);
    if (exact) begin
      check_value("store done delay", edges, 3);
    end
    model_store(addr, sz, data);
  endtask

  task automatic load_op(input addr_t addr, input acc_size_t sz, input logic uns,
                         input logic exact);
    xlen_t rdata;
    logic  err;
    int    edges;
    lsu_access(1'b0, addr, sz, uns, '0, rdata, err, edges);
    check_value("load error flag", err, 0);
    check_value("load data", rdata, model_load(addr, sz, uns));
    if (exact) begin
      check_value("load done delay", edges, 3);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // count sampled on rising edges, away from the monitor's falling edge
  task automatic wait_instrs(input int n);
    int target;
    int cycles;
    target = instr_count + n;
    cycles = 0;
    while (instr_count < target && cycles < n * OP_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    @(negedge clk);
    if (instr_count < target) begin
      $display("fetch stalled with %0d of %0d instructions", n - target + instr_count, n);
      error_count++;
    end
  endtask

  task automatic open_test();
    test_start_errors = error_count;
  endtask

  task automatic close_test(input string name);
    $display("%s: %0d errors", name, error_count - test_start_errors);
  endtask

  // redirect seen by the DUT at this edge
  always @(posedge clk) begin
    if (!rst && redirect) begin
      expect_pc      = redirect_pc;
      after_redirect = 1'b1;
    end
  end

  // instruction stream against the model
  always @(negedge clk) begin
    if (!rst && instr_valid) begin
      if (after_redirect) begin
        check_value("first pc after redirect", instr_pc, expect_pc);
      end else begin
        check_value("fetch pc order", instr_pc, expect_pc);
      end
      check_value("fetched instruction", instr, model_instr(instr_pc));
      expect_pc      = instr_pc + 4;
      after_redirect = 1'b0;
      instr_count++;
    end
  end

  initial begin
    #(TOTAL_OPS * OP_CYCLES * CLK_PERIOD);
    $display("timeout, the tests did not finish in time");
    $display("Something failed");
    $finish;
  end

  initial begin
    addr_t     addr;
    addr_t     base;
    acc_size_t sz;
    xlen_t     rdata;
    logic      err;
    int        edges;
    int        k;
    clk            = 1'b0;
    rst            = 1'b1;
    fetch_en       = 1'b0;
    redirect       = 1'b0;
    redirect_pc    = '0;
    lsu_req        = 1'b0;
    lsu_we         = 1'b0;
    lsu_addr       = '0;
    lsu_size       = SZ_B;
    lsu_unsigned   = 1'b0;
    lsu_wdata      = '0;
    seed           = 32'ha47e;
    check_count    = 0;
    error_count    = 0;
    instr_count    = 0;
    expect_pc      = `MEM_RESET_PC;
    after_redirect = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;

    open_test();
    for (int c = 0; c < 20; c++) begin
      @(negedge clk);
      check_value("instr_valid while idle", instr_valid, 0);
      check_value("lsu_done while idle", lsu_done, 0);
    end
    close_test("test 1 idle after reset");

    open_test();
    for (int i = 0; i < N_STORES; i++) begin
      sz   = acc_size_t'(rand_below(4));
      addr = aligned_data_addr(sz);
      addr_list.push_back(addr);
      size_list.push_back(sz);
      store_op(addr, sz, {$random(seed), $random(seed)}, 1'b1);
    end
    foreach (addr_list[i]) begin
      load_op(addr_list[i], size_list[i], rand_below(2) == 1, 1'b1);
    end
    close_test("test 2 sized stores and loads");

    open_test();
    for (int i = 0; i < N_MISALIGNED; i++) begin
      sz   = acc_size_t'(1 + rand_below(3));
      base = addr_list[rand_below(addr_list.size())] & ~addr_t'(7);
      // whole doubleword known before the rejected access
      store_op(base, SZ_D, {$random(seed), $random(seed)}, 1'b1);
      // odd offset is misaligned for every size above a byte
      addr = base + (rand_below(8) | 1);
      lsu_access(rand_below(2) == 1, addr, sz, 1'b0, {$random(seed), $random(seed)},
                 rdata, err, edges);
      check_value("misaligned error flag", err, 1);
      check_value("misaligned done delay", edges, 0);
      load_op(base, SZ_D, 1'b0, 1'b1);
    end
    close_test("test 3 misaligned accesses");

    open_test();
    // instruction region 0x000 to 0xfff
    for (int w = 0; w < FILL_WORDS; w++) begin
      store_op(w * 8, SZ_D, {$random(seed), $random(seed)}, 1'b0);
    end
    fetch_en = 1'b1;
    wait_instrs(N_FETCH);
    fetch_en = 1'b0;
    idle_cycles(12);
    close_test("test 4 sequential fetch");

    open_test();
    fetch_en = 1'b1;
    for (int i = 0; i < N_MIXED; i++) begin
      if (rand_below(2) == 0) begin
        sz   = acc_size_t'(rand_below(4));
        addr = aligned_data_addr(sz);
        addr_list.push_back(addr);
        size_list.push_back(sz);
        store_op(addr | (HIGH_BITS & $random(seed)), sz, {$random(seed), $random(seed)}, 1'b0);
      end else begin
        k = rand_below(addr_list.size());
        load_op(addr_list[k] | (HIGH_BITS & $random(seed)), size_list[k],
                rand_below(2) == 1, 1'b0);
      end
      idle_cycles(rand_below(3));
    end
    fetch_en = 1'b0;
    idle_cycles(12);
    close_test("test 5 loads and stores with fetch");

    open_test();
    fetch_en = 1'b1;
    for (int r = 0; r < N_REDIRECTS; r++) begin
      redirect    = 1'b1;
      redirect_pc = rand_below(512) * 4;
      @(negedge clk);
      redirect = 1'b0;
      wait_instrs(1 + rand_below(3));
      // vary where the next redirect lands in the fetch cycle
      idle_cycles(rand_below(4));
    end
    fetch_en = 1'b0;
    idle_cycles(12);
    close_test("test 6 redirects");

    assert_fails = mem_subsys_inst.ram_arb_inst.mem_subsys_assertions_inst.fail_count;
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/sram_bank.sv
verilog/ram_arb.sv
verilog/fetch_unit.sv
verilog/load_store_unit.sv
verilog/mem_subsys.sv
tb/mem_subsys_assertions.sv
tb/mem_subsys_tb.sv
